// ==== src/mem_ex_pkg.sv ====
package mem_ex_pkg;

    // operand count and field widths
    localparam int NUM_OPS = 2;
    localparam int TAG_W   = 4;
    localparam int VAL_W   = 32;
    localparam int CTRL_W  = 16;

    typedef logic [TAG_W-1:0]   ptc_tag_t;
    typedef logic [VAL_W-1:0]   op_val_t;
    typedef logic [CTRL_W-1:0]  ctrl_word_t;
    typedef logic [NUM_OPS-1:0] wake_t;

    // modifiable part, lsb first: values, then tags, then wake bits
    localparam int VAL_LSB   = 0;
    localparam int TAG_LSB   = NUM_OPS * VAL_W;
    localparam int WAKE_LSB  = TAG_LSB + NUM_OPS * TAG_W;
    localparam int ENTRY_M_W = WAKE_LSB + NUM_OPS;

    typedef logic [ENTRY_M_W-1:0] entry_m_t;

    // operand 0 is op1, it sits in the low slot of each field
    function automatic entry_m_t pack_entry(wake_t w, ptc_tag_t t1, ptc_tag_t t2,
                                            op_val_t v1, op_val_t v2);
        return {w, t2, t1, v2, v1};
    endfunction

    function automatic ptc_tag_t op_tag(entry_m_t e, int i);
        return e[TAG_LSB + i*TAG_W +: TAG_W];
    endfunction

    function automatic op_val_t op_val(entry_m_t e, int i);
        return e[VAL_LSB + i*VAL_W +: VAL_W];
    endfunction

    function automatic wake_t op_wake(entry_m_t e);
        return e[WAKE_LSB +: NUM_OPS];
    endfunction

endpackage

// ==== src/entry_patch_if.sv ====
`timescale 1ns/100ps

// stored modifiable parts out, patches back in
interface entry_patch_if import mem_ex_pkg::*; #(parameter int Q_LENGTH = 8);

    // driven by the queue
    entry_m_t            entries_m [Q_LENGTH];
    logic [Q_LENGTH-1:0] entry_valid;

    // driven by the wakeup unit, combinational
    logic [Q_LENGTH-1:0] modify;
    entry_m_t            new_m [Q_LENGTH];

    modport queue_side (
        output entries_m, entry_valid,
        input  modify, new_m
    );

    modport wakeup_side (
        input  entries_m, entry_valid,
        output modify, new_m
    );

endinterface

// ==== src/head_if.sv ====
`timescale 1ns/100ps

// head entry from the queue, pop strobe back
interface head_if import mem_ex_pkg::*;;

    entry_m_t   head_m;
    ctrl_word_t head_n;
    logic       empty;
    // one cycle, from the issue stage
    logic       pop;

    modport queue_side (
        output head_m, head_n, empty,
        input  pop
    );

    modport issue_side (
        input  head_m, head_n, empty,
        output pop
    );

endinterface

// ==== src/operand_wakeup.sv ====
`timescale 1ns/100ps

module operand_wakeup import mem_ex_pkg::*; #(
    parameter int Q_LENGTH = 8
) (
    entry_patch_if.wakeup_side patch,
    input  logic               wb_valid,
    input  ptc_tag_t           wb_tag,
    input  op_val_t            wb_value
);

    // one comparator set per slot
    for (genvar s = 0; s < Q_LENGTH; s++) begin : g_slot
        entry_m_t patched;
        logic     hit;

        always_comb begin
            // default is the stored part untouched
            patched = patch.entries_m[s];
            hit     = 1'b0;
            for (int i = 0; i < NUM_OPS; i++) begin
                // only pending operands of occupied slots can wake
                if (wb_valid && patch.entry_valid[s] &&
                    !patch.entries_m[s][WAKE_LSB + i] &&
                    op_tag(patch.entries_m[s], i) == wb_tag) begin
                    patched[WAKE_LSB + i]                  = 1'b1;
                    patched[VAL_LSB + i*VAL_W +: VAL_W]    = wb_value;
                    hit                                    = 1'b1;
                end
            end
        end

        // queue writes new_m back only where modify is set
        assign patch.new_m[s]  = patched;
        assign patch.modify[s] = hit;
    end

endmodule

// ==== src/queued_latch.sv ====
`timescale 1ns/100ps

module queued_latch import mem_ex_pkg::*; #(
    parameter int Q_LENGTH = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wr,
    input  entry_m_t          din_m,
    input  ctrl_word_t        din_n,
    input  logic              flush,
    output logic              full,
    entry_patch_if.queue_side patch,
    head_if.queue_side        head
);

    localparam int PTR_W = (Q_LENGTH > 1) ? $clog2(Q_LENGTH) : 1;
    localparam int CNT_W = $clog2(Q_LENGTH + 1);

    // split storage, modifiable part and fixed control word
    entry_m_t   mem_m [Q_LENGTH];
    ctrl_word_t mem_n [Q_LENGTH];

    logic [Q_LENGTH-1:0] valid;
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    count;
    logic                do_wr;
    logic                do_pop;

    // wrap for any length, not only powers of two
    function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] p);
        return (p == PTR_W'(Q_LENGTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full       = (count == CNT_W'(Q_LENGTH));
    assign head.empty = (count == '0);

    // write while full is dropped
    assign do_wr  = wr && !full;
    assign do_pop = head.pop && !head.empty;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            valid  <= '0;
        end else if (flush) begin
            // flush wins over write and pop
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            valid  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr        <= ptr_inc(wr_ptr);
                valid[wr_ptr] <= 1'b1;
            end
            if (do_pop) begin
                rd_ptr        <= ptr_inc(rd_ptr);
                valid[rd_ptr] <= 1'b0;
            end
            case ({do_wr, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        // in-place wakeup patches
        for (int s = 0; s < Q_LENGTH; s++) begin
            if (patch.modify[s]) begin
                mem_m[s] <= patch.new_m[s];
            end
        end
        // tail slot is empty, so no patch collides with it
        if (do_wr) begin
            mem_m[wr_ptr] <= din_m;
            mem_n[wr_ptr] <= din_n;
        end
    end

    assign patch.entries_m   = mem_m;
    assign patch.entry_valid = valid;

    assign head.head_m = mem_m[rd_ptr];
    assign head.head_n = mem_n[rd_ptr];

endmodule

// ==== src/ex_issue_gate.sv ====
`timescale 1ns/100ps

module ex_issue_gate import mem_ex_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    head_if.issue_side  head,
    input  logic        ex_stall,
    output logic        ex_valid,
    output ctrl_word_t  ex_ctrl,
    output op_val_t     ex_op1,
    output op_val_t     ex_op2,
    input  logic        flush
);

    logic head_ready;

    // all operands woken in the stored copy
    assign head_ready = !head.empty && (&op_wake(head.head_m));

    // no pop under stall, flush drops the cycle
    assign head.pop = head_ready && !ex_stall && !flush;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else if (flush) begin
            ex_valid <= 1'b0;
        end else if (!ex_stall) begin
            // bubble when nothing pops
            ex_valid <= head.pop;
        end
    end

    // payload held unless a pop loads it
    always_ff @(posedge clk) begin
        if (head.pop) begin
            ex_ctrl <= head.head_n;
            ex_op1  <= op_val(head.head_m, 0);
            ex_op2  <= op_val(head.head_m, 1);
        end
    end

endmodule

// ==== src/mem_ex_latch_top.sv ====
`timescale 1ns/100ps

module mem_ex_latch_top import mem_ex_pkg::*; #(
    parameter int Q_LENGTH = 8
) (
    input  logic       clk,
    input  logic       rst_n,
    // entry from the memory stage
    input  logic       wr,
    input  ptc_tag_t   in_tag1,
    input  ptc_tag_t   in_tag2,
    input  wake_t      in_wake,
    input  op_val_t    in_val1,
    input  op_val_t    in_val2,
    input  ctrl_word_t in_ctrl,
    input  logic       flush,
    // writeback broadcast
    input  logic       wb_valid,
    input  ptc_tag_t   wb_tag,
    input  op_val_t    wb_value,
    // execute side
    input  logic       ex_stall,
    output logic       full,
    output logic       ex_valid,
    output ctrl_word_t ex_ctrl,
    output op_val_t    ex_op1,
    output op_val_t    ex_op2
);

    entry_m_t din_m;

    entry_patch_if #(.Q_LENGTH(Q_LENGTH)) i_entry_patch_if ();
    head_if                               i_head_if ();

    // wake bits, tags and values into one modifiable word
    assign din_m = pack_entry(in_wake, in_tag1, in_tag2, in_val1, in_val2);

    operand_wakeup #(.Q_LENGTH(Q_LENGTH)) i_operand_wakeup (
        .patch    (i_entry_patch_if.wakeup_side),
        .wb_valid (wb_valid),
        .wb_tag   (wb_tag),
        .wb_value (wb_value)
    );

    queued_latch #(.Q_LENGTH(Q_LENGTH)) i_queued_latch (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (wr),
        .din_m (din_m),
        .din_n (in_ctrl),
        .flush (flush),
        .full  (full),
        .patch (i_entry_patch_if.queue_side),
        .head  (i_head_if.queue_side)
    );

    ex_issue_gate i_ex_issue_gate (
        .clk      (clk),
        .rst_n    (rst_n),
        .head     (i_head_if.issue_side),
        .ex_stall (ex_stall),
        .ex_valid (ex_valid),
        .ex_ctrl  (ex_ctrl),
        .ex_op1   (ex_op1),
        .ex_op2   (ex_op2),
        .flush    (flush)
    );

endmodule

// ==== tests/mem_ex_model.svh ====
`ifndef MEM_EX_MODEL_SVH
`define MEM_EX_MODEL_SVH

// one queued instruction as the model sees it
typedef struct packed {
    ctrl_word_t ctrl;
    wake_t      wake;
    ptc_tag_t   tag2;
    ptc_tag_t   tag1;
    op_val_t    val2;
    op_val_t    val1;
} model_entry_t;

// queue contents, head at index 0
model_entry_t mq [$];

// output register state
logic       m_valid;
ctrl_word_t m_ctrl;
op_val_t    m_op1;
op_val_t    m_op2;
int         issued;

task automatic clear_model();
    mq.delete();
    m_valid = 1'b0;
endtask

// tag of the oldest operand still waiting, 0 when nothing waits
function automatic ptc_tag_t pending_tag();
    foreach (mq[i]) begin
        if (!mq[i].wake[0]) return mq[i].tag1;
        if (!mq[i].wake[1]) return mq[i].tag2;
    end
    return '0;
endfunction

// one clock edge with the inputs of this cycle
task automatic advance_model(input logic wr_i, input model_entry_t new_e, input logic flush_i,
                             input logic wb_v, input ptc_tag_t wb_t, input op_val_t wb_val,
                             input logic stall_i);
    logic         pop;
    logic         was_full;
    model_entry_t e;
    if (flush_i) begin
        // flush beats write and pop
        mq.delete();
        m_valid = 1'b0;
    end else begin
        was_full = (mq.size() == Q_LENGTH);
        // readiness from stored wake bits, before this cycle's broadcast
        pop = (mq.size() > 0) && (mq[0].wake == 2'b11) && !stall_i;
        if (wb_v) begin
            foreach (mq[i]) begin
                e = mq[i];
                if (!e.wake[0] && e.tag1 == wb_t) begin
                    e.wake[0] = 1'b1;
                    e.val1    = wb_val;
                end
                if (!e.wake[1] && e.tag2 == wb_t) begin
                    e.wake[1] = 1'b1;
                    e.val2    = wb_val;
                end
                mq[i] = e;
            end
        end
        if (pop) begin
            e       = mq.pop_front();
            m_valid = 1'b1;
            m_ctrl  = e.ctrl;
            m_op1   = e.val1;
            m_op2   = e.val2;
            issued++;
        end else if (!stall_i) begin
            m_valid = 1'b0;
        end
        // full is judged on the count before the pop
        if (wr_i && !was_full) mq.push_back(new_e);
    end
endtask

`endif

// ==== tests/tb_mem_ex_latch.sv ====
`timescale 1ns/100ps

module tb_mem_ex_latch import mem_ex_pkg::*;;

    localparam int Q_LENGTH    = 8;
    localparam int SEED        = 89706;
    localparam int NUM_WRITES  = 400;
    // generous budget per accepted write, drain included
    localparam int CYCLE_LIMIT = NUM_WRITES * 50;

    logic       clk;
    logic       rst_n;
    logic       wr;
    ptc_tag_t   in_tag1;
    ptc_tag_t   in_tag2;
    wake_t      in_wake;
    op_val_t    in_val1;
    op_val_t    in_val2;
    ctrl_word_t in_ctrl;
    logic       flush;
    logic       wb_valid;
    ptc_tag_t   wb_tag;
    op_val_t    wb_value;
    logic       ex_stall;
    logic       full;
    logic       ex_valid;
    ctrl_word_t ex_ctrl;
    op_val_t    ex_op1;
    op_val_t    ex_op2;

    int           errors;
    int           writes;
    int           cycles;
    logic         reset_done;

    `include "mem_ex_model.svh"

    model_entry_t new_e;

    mem_ex_latch_top #(.Q_LENGTH(Q_LENGTH)) i_mem_ex_latch_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr       (wr),
        .in_tag1  (in_tag1),
        .in_tag2  (in_tag2),
        .in_wake  (in_wake),
        .in_val1  (in_val1),
        .in_val2  (in_val2),
        .in_ctrl  (in_ctrl),
        .flush    (flush),
        .wb_valid (wb_valid),
        .wb_tag   (wb_tag),
        .wb_value (wb_value),
        .ex_stall (ex_stall),
        .full     (full),
        .ex_valid (ex_valid),
        .ex_ctrl  (ex_ctrl),
        .ex_op1   (ex_op1),
        .ex_op2   (ex_op2)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic ctrl_check(input ctrl_word_t got, input ctrl_word_t exp);
        if (got !== exp) begin
            $display("ERR %0t: ex_ctrl got %h expected %h", $time, got, exp);
            errors++;
        end
    endtask

    task automatic value_check(input op_val_t got, input op_val_t exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic flag_check(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // outputs are stable at the falling edge
    task automatic compare_outputs();
        flag_check(full, mq.size() == Q_LENGTH, "full");
        flag_check(ex_valid, m_valid, "ex_valid");
        if (m_valid) begin
            ctrl_check(ex_ctrl, m_ctrl);
            value_check(ex_op1, m_op1, "ex_op1");
            value_check(ex_op2, m_op2, "ex_op2");
        end
    endtask

    task automatic idle_inputs();
        wr       = 1'b0;
        in_tag1  = '0;
        in_tag2  = '0;
        in_wake  = '0;
        in_val1  = '0;
        in_val2  = '0;
        in_ctrl  = '0;
        flush    = 1'b0;
        wb_valid = 1'b0;
        wb_tag   = '0;
        wb_value = '0;
        ex_stall = 1'b0;
    endtask

    // random traffic for one cycle, drain mode once all writes are in
    task automatic drive_cycle(input logic drain);
        rst_n    = 1'b1;
        wr       = !drain && ($urandom % 3 != 0);
        in_tag1  = ptc_tag_t'($urandom);
        in_tag2  = ptc_tag_t'($urandom);
        in_wake  = wake_t'($urandom);
        in_val1  = $urandom;
        in_val2  = $urandom;
        in_ctrl  = ctrl_word_t'($urandom);
        flush    = !drain && ($urandom % 97 == 0);
        wb_value = $urandom;
        ex_stall = ($urandom % 4 == 0);
        if (drain) begin
            wb_valid = 1'b1;
            wb_tag   = pending_tag();
        end else begin
            wb_valid = 1'($urandom % 2);
            // half the broadcasts aim at a waiting operand
            wb_tag   = ($urandom % 2) ? pending_tag() : ptc_tag_t'($urandom);
        end
    endtask

    initial begin
        errors     = 0;
        writes     = 0;
        issued     = 0;
        reset_done = 1'b0;
        void'($urandom(SEED));
        rst_n      = 1'b0;
        idle_inputs();
        clear_model();
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        compare_outputs();
        while (!(writes >= NUM_WRITES && mq.size() == 0 && !m_valid)) begin
            if (writes == NUM_WRITES / 2 && !reset_done) begin
                // one reset in the middle of traffic, three cycles long
                reset_done = 1'b1;
                rst_n      = 1'b0;
                idle_inputs();
                clear_model();
                repeat (2) begin
                    @(negedge clk);
                    compare_outputs();
                end
            end else begin
                drive_cycle(writes >= NUM_WRITES);
                new_e.ctrl = in_ctrl;
                new_e.wake = in_wake;
                new_e.tag1 = in_tag1;
                new_e.tag2 = in_tag2;
                new_e.val1 = in_val1;
                new_e.val2 = in_val2;
                if (wr && !flush && mq.size() < Q_LENGTH) writes++;
                advance_model(wr, new_e, flush, wb_valid, wb_tag, wb_value, ex_stall);
            end
            @(negedge clk);
            compare_outputs();
        end
        if (issued == 0) begin
            $display("no entry was issued during the run");
            errors++;
        end
        $display("writes: %0d issued: %0d errors: %0d", writes, issued, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // watchdog on rising edges
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("run timed out after %0d cycles with %0d errors", cycles, errors);
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+tests
src/mem_ex_pkg.sv
src/entry_patch_if.sv
src/head_if.sv
src/operand_wakeup.sv
src/queued_latch.sv
src/ex_issue_gate.sv
src/mem_ex_latch_top.sv
tests/tb_mem_ex_latch.sv

// ==== Bender.yml ====
package:
  name: mem_ex_latch

sources:
  - src/mem_ex_pkg.sv
  - src/entry_patch_if.sv
  - src/head_if.sv
  - src/operand_wakeup.sv
  - src/queued_latch.sv
  - src/ex_issue_gate.sv
  - src/mem_ex_latch_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_mem_ex_latch.sv
